// ==== logic/arb_pkg.sv ====
package arb_pkg;

    // client count and the two-level split
    localparam int NUM_CLIENTS = 8;
    localparam int GROUP_NUM   = 4;                        // root arbiter width
    localparam int GROUP_WIDTH = NUM_CLIENTS / GROUP_NUM;  // clients per group

    // one bit per client: requests, grants, read valids
    typedef logic [NUM_CLIENTS-1:0] client_vec_t;

endpackage

// ==== logic/mem_pkg.sv ====
package mem_pkg;

    // shared memory geometry
    localparam int ADDR_WIDTH = 6;   // 64 words
    localparam int DATA_WIDTH = 16;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

endpackage

// ==== logic/rr_arbiter.sv ====
`timescale 1ns/1ps

// round-robin arbiter, thermometer coded
// pointer only moves while priority_en is high, so a locked winner keeps the grant
module rr_arbiter #(
    parameter int WIDTH = 4    // 2 or more
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] request,
    input  logic             priority_en,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    logic [WIDTH-1:0] pr;             // ones above the last winner
    logic [WIDTH-1:0] masked_req;
    logic [WIDTH-1:0] thermo_raw;
    logic [WIDTH-1:0] thermo_masked;
    logic [WIDTH-1:0] mux_out;
    logic [WIDTH-1:0] edge_mask;

    assign masked_req = request & pr;

    // bit i set once any request at or below i is seen
    for (genvar i = 0; i < WIDTH; i++) begin : g_thermo
        assign thermo_raw[i]    = |request[i:0];
        assign thermo_masked[i] = |masked_req[i:0];
    end

    // prefer requests above the pointer, wrap to the raw code otherwise
    assign mux_out   = thermo_masked[WIDTH-1] ? thermo_masked : thermo_raw;
    assign edge_mask = {mux_out[WIDTH-2:0], 1'b0};
    assign grant     = mux_out ^ edge_mask;    // lowest set bit of the code
    assign any_grant = thermo_raw[WIDTH-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pr <= '1;    // lowest index wins first
        end else if (priority_en) begin
            pr <= edge_mask;
        end
    end

endmodule

// ==== logic/tree_arbiter.sv ====
`timescale 1ns/1ps

// two-level round-robin: one arbiter per group, a root arbiter across groups
module tree_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  arb_pkg::client_vec_t request,
    input  logic                advance,    // low while the winner holds lock
    output arb_pkg::client_vec_t grant
);

    import arb_pkg::*;

    logic [GROUP_WIDTH-1:0] group_req   [GROUP_NUM];
    logic [GROUP_WIDTH-1:0] group_grant [GROUP_NUM];
    logic [GROUP_NUM-1:0]   group_any;     // OR of each group's requests
    logic [GROUP_NUM-1:0]   root_grant;
    logic                   root_any;

    for (genvar g = 0; g < GROUP_NUM; g++) begin : g_group
        assign group_req[g] = request[g*GROUP_WIDTH +: GROUP_WIDTH];

        // only the group picked by the root may move its pointer
        rr_arbiter #(
            .WIDTH       (GROUP_WIDTH)
        ) group_arb (
            .clk         (clk),
            .rst_n       (rst_n),
            .request     (group_req[g]),
            .priority_en (root_grant[g] & advance),
            .grant       (group_grant[g]),
            .any_grant   (group_any[g])
        );

        assign grant[g*GROUP_WIDTH +: GROUP_WIDTH] =
            root_grant[g] ? group_grant[g] : '0;    // drop losing groups
    end

    // group any_grant doubles as the root request
    rr_arbiter #(
        .WIDTH       (GROUP_NUM)
    ) root_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .request     (group_any),
        .priority_en (advance & root_any),    // hold pointer when idle
        .grant       (root_grant),
        .any_grant   (root_any)
    );

endmodule

// ==== logic/grant_mux.sv ====
`timescale 1ns/1ps

// picks the payload of the granted client
// grant is one-hot or zero, so an AND-OR tree is enough
module grant_mux #(
    parameter type payload_t = logic
) (
    input  arb_pkg::client_vec_t                    grant,
    input  payload_t [arb_pkg::NUM_CLIENTS-1:0]     payload,
    output payload_t                                selected
);

    import arb_pkg::*;

    always_comb begin
        selected = '0;    // nothing granted gives zero
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            if (grant[i]) begin
                selected = selected | payload[i];
            end
        end
    end

endmodule

// ==== logic/shared_mem.sv ====
`timescale 1ns/1ps

// single-port memory behind the arbiter
// reads come back one cycle later, tagged with the requesting client
module shared_mem (
    input  logic                 clk,
    input  logic                 rst_n,
    input  arb_pkg::client_vec_t grant,
    input  logic                 we,
    input  mem_pkg::addr_t       addr,
    input  mem_pkg::data_t       wdata,
    output mem_pkg::data_t       rd_data,
    output arb_pkg::client_vec_t rd_valid
);

    import mem_pkg::*;

    data_t mem [2**ADDR_WIDTH];

    // one access per cycle, write or read
    always_ff @(posedge clk) begin
        if (|grant) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rd_data <= mem[addr];
            end
        end
    end

    // read valid follows the winner by one edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= '0;
        end else begin
            rd_valid <= grant & {$bits(grant){~we}};    // writes return nothing
        end
    end

endmodule

// ==== logic/shared_mem_hub.sv ====
`timescale 1ns/1ps

// eight clients sharing one memory through the tree arbiter
module shared_mem_hub (
    input  logic                                         clk,
    input  logic                                         rst_n,

    // client side
    input  arb_pkg::client_vec_t                         req,
    input  arb_pkg::client_vec_t                         we,
    input  arb_pkg::client_vec_t                         lock,
    input  mem_pkg::addr_t [arb_pkg::NUM_CLIENTS-1:0]    addr,
    input  mem_pkg::data_t [arb_pkg::NUM_CLIENTS-1:0]    wdata,

    output arb_pkg::client_vec_t                         grant,
    output arb_pkg::client_vec_t                         rd_valid,
    output mem_pkg::data_t                               rd_data    // shared by all clients
);

    import mem_pkg::*;

    addr_t sel_addr;
    data_t sel_wdata;
    logic  sel_we;
    logic  sel_lock;
    logic  advance;

    // locked winner freezes all pointers
    assign advance = ~sel_lock;

    tree_arbiter arb_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .request  (req),
        .advance  (advance),
        .grant    (grant)
    );

    // winner's payload
    grant_mux #(
        .payload_t (addr_t)
    ) addr_mux (
        .grant     (grant),
        .payload   (addr),
        .selected  (sel_addr)
    );

    grant_mux #(
        .payload_t (data_t)
    ) wdata_mux (
        .grant     (grant),
        .payload   (wdata),
        .selected  (sel_wdata)
    );

    grant_mux #(
        .payload_t (logic)
    ) we_mux (
        .grant     (grant),
        .payload   (we),
        .selected  (sel_we)
    );

    grant_mux #(
        .payload_t (logic)
    ) lock_mux (
        .grant     (grant),
        .payload   (lock),
        .selected  (sel_lock)
    );

    shared_mem mem_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .grant    (grant),
        .we       (sel_we),
        .addr     (sel_addr),
        .wdata    (sel_wdata),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

// ==== bench/hub_assert.sv ====
`timescale 1ns/1ps

// grant legality checks, bound into the hub
module hub_assert (
    input  logic                 clk,
    input  logic                 rst_n,
    input  arb_pkg::client_vec_t req,
    input  arb_pkg::client_vec_t we,
    input  arb_pkg::client_vec_t grant,
    input  arb_pkg::client_vec_t rd_valid
);

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant))
        else $error("grant has more than one bit set");

    grant_subset: assert property (@(posedge clk) disable iff (!rst_n)
        (grant & ~req) == '0)
        else $error("grant given to a client that is not requesting");

    // winner reading gets exactly its own valid bit one cycle later
    read_valid: assert property (@(posedge clk) disable iff (!rst_n)
        |(grant & ~we) |=> rd_valid == $past(grant))
        else $error("read grant not followed by the matching rd_valid");

endmodule

bind shared_mem_hub hub_assert hub_assert_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .we       (we),
    .grant    (grant),
    .rd_valid (rd_valid)
);

// ==== bench/hub_tb.sv ====
`timescale 1ns/1ps

module hub_tb;

    import arb_pkg::*;
    import mem_pkg::*;

    localparam int TIMEOUT = 50;

    logic clk;
    logic rst_n;
    client_vec_t req, we, lock, grant, rd_valid;
    addr_t [NUM_CLIENTS-1:0] addr;
    data_t [NUM_CLIENTS-1:0] wdata;
    data_t rd_data;

    // reference model state
    int          group_ptr [GROUP_NUM];    // lowest index allowed to win first
    int          root_ptr;
    data_t       ref_mem [2**ADDR_WIDTH];
    bit          ref_written [2**ADDR_WIDTH];
    client_vec_t pend_valid;               // read result due next cycle
    data_t       pend_data;
    bit          pend_known;

    logic [31:0] lcg_state = 32'hdb4c;
    string       test_name = "reset";
    int          mismatch_errors = 0;
    int          timeout_errors = 0;
    int          rr_order [8] = '{0, 2, 4, 6, 1, 3, 5, 7};

    shared_mem_hub dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .we       (we),
        .lock     (lock),
        .addr     (addr),
        .wdata    (wdata),
        .grant    (grant),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // lowest requester at or above ptr, else wrap to the lowest one
    function automatic int rr_pick(input logic [3:0] reqs, input int width, input int ptr);
        for (int i = ptr; i < width; i++) begin
            if (reqs[i]) begin
                return i;
            end
        end
        for (int i = 0; i < width; i++) begin
            if (reqs[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic client_vec_t expected_grant(input client_vec_t r);
        logic [3:0]  grp_req;
        logic [3:0]  in_grp;
        int          g;
        int          c;
        client_vec_t result;
        result = '0;
        for (int k = 0; k < GROUP_NUM; k++) begin
            grp_req[k] = |r[k*GROUP_WIDTH +: GROUP_WIDTH];
        end
        g = rr_pick(grp_req, GROUP_NUM, root_ptr);
        if (g >= 0) begin
            in_grp = '0;
            in_grp[GROUP_WIDTH-1:0] = r[g*GROUP_WIDTH +: GROUP_WIDTH];
            c = rr_pick(in_grp, GROUP_WIDTH, group_ptr[g]);
            result[g*GROUP_WIDTH + c] = 1'b1;
        end
        return result;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        mismatch_errors++;
        $display("Mismatch in %s (%s): expected %0h, actual %0h",
                 test_name, what, expected, actual);
    endtask

    // compare at the falling edge, inputs and outputs settled
    always @(negedge clk) begin
        client_vec_t exp_grant;
        int          win;
        if (!rst_n) begin
            for (int g = 0; g < GROUP_NUM; g++) begin
                group_ptr[g] = 0;
            end
            root_ptr   = 0;
            pend_valid = '0;
        end else begin
            if (rd_valid !== pend_valid) begin
                report_mismatch("rd_valid", 32'(pend_valid), 32'(rd_valid));
            end else if (|pend_valid && pend_known && rd_data !== pend_data) begin
                report_mismatch("rd_data", 32'(pend_data), 32'(rd_data));
            end
            exp_grant = expected_grant(req);
            if (grant !== exp_grant) begin
                report_mismatch("grant", 32'(exp_grant), 32'(grant));
            end
            win = -1;
            for (int i = 0; i < NUM_CLIENTS; i++) begin
                if (exp_grant[i]) begin
                    win = i;
                end
            end
            pend_valid = '0;
            if (win >= 0) begin
                if (we[win]) begin
                    ref_mem[addr[win]]     = wdata[win];
                    ref_written[addr[win]] = 1'b1;
                end else begin
                    pend_valid = exp_grant;
                    pend_data  = ref_mem[addr[win]];
                    pend_known = ref_written[addr[win]];
                end
                if (!lock[win]) begin    // lock freezes every pointer
                    group_ptr[win / GROUP_WIDTH] = win % GROUP_WIDTH + 1;
                    root_ptr = win / GROUP_WIDTH + 1;
                end
            end
        end
    end

    task automatic wait_grant(input int idx);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!grant[idx] && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!grant[idx]) begin
            timeout_errors++;
            $display("timeout: client %0d was never granted in %s", idx, test_name);
        end
    endtask

    task automatic wait_rd_valid();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (rd_valid == '0 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rd_valid == '0) begin
            timeout_errors++;
            $display("timeout: no read data returned in %s", test_name);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        req   <= '0;
        lock  <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        req   = '0;
        we    = '0;
        lock  = '0;
        addr  = '0;
        wdata = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // idle hub after reset
        @(negedge clk);
        if (grant !== '0) begin
            report_mismatch("idle grant", 32'h0, 32'(grant));
        end
        if (rd_valid !== '0) begin
            report_mismatch("idle rd_valid", 32'h0, 32'(rd_valid));
        end

        test_name = "single_client";
        @(posedge clk);
        req[3]   <= 1'b1;
        we[3]    <= 1'b1;
        addr[3]  <= 6'h15;
        wdata[3] <= 16'hbeef;
        wait_grant(3);
        @(posedge clk);    // write lands here
        we[3] <= 1'b0;     // read back the same word
        wait_grant(3);
        @(posedge clk);
        req[3] <= 1'b0;
        wait_rd_valid();
        if (rd_valid !== 8'h08) begin
            report_mismatch("read valid bit", 32'h08, 32'(rd_valid));
        end
        if (rd_data !== 16'hbeef) begin
            report_mismatch("read data", 32'hbeef, 32'(rd_data));
        end

        test_name = "all_requesting";
        apply_reset();
        @(posedge clk);
        we  <= '0;
        req <= '1;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (grant !== client_vec_t'(1) << rr_order[i % 8]) begin
                report_mismatch("rr order", 32'(1) << rr_order[i % 8], 32'(grant));
            end
        end

        test_name = "lock_hold";
        @(posedge clk);
        lock[5] <= 1'b1;
        wait_grant(5);
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            if (grant !== 8'h20) begin
                report_mismatch("locked grant", 32'h20, 32'(grant));
            end
        end
        @(posedge clk);
        lock[5] <= 1'b0;    // pointers move on from here
        repeat (4) @(posedge clk);
        req <= '0;

        test_name = "random_traffic";
        for (int n = 0; n < 400; n++) begin
            @(posedge clk);
            req  <= client_vec_t'(lcg_next() >> 16);
            we   <= client_vec_t'(lcg_next() >> 16);
            lock <= client_vec_t'(lcg_next() >> 16) & client_vec_t'(lcg_next() >> 20);
            for (int i = 0; i < NUM_CLIENTS; i++) begin
                addr[i]  <= addr_t'(lcg_next() >> 16);
                wdata[i] <= data_t'(lcg_next() >> 12);
            end
        end
        @(posedge clk);
        req  <= '0;
        lock <= '0;
        repeat (3) @(posedge clk);

        $display("errors: %0d mismatches, %0d timeouts", mismatch_errors, timeout_errors);
        if (mismatch_errors == 0 && timeout_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/arb_pkg.sv
logic/mem_pkg.sv
logic/rr_arbiter.sv
logic/tree_arbiter.sv
logic/grant_mux.sv
logic/shared_mem.sv
logic/shared_mem_hub.sv
bench/hub_assert.sv
bench/hub_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = hub_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides the result
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
